// ==== design/bridge_settings.svh ====
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// AXI slave port
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 64

// APB side, one word per transfer
`define APB_DATA_WIDTH 32

// per-slave span, 4 KB each
`define APB_ADDR_WIDTH 12
`define APB_NUM_SLAVES 8
`define APB_SEL_WIDTH 3

// entries per channel FIFO
`define BUFFER_DEPTH 2

`endif

// ==== design/axi_pkg.sv ====
`include "bridge_settings.svh"

package axi_pkg;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_e;

	typedef struct packed {
		logic [`AXI_ADDR_WIDTH-1:0] addr;
		logic [2:0]                 size;
	} aw_t;

	typedef struct packed {
		logic [`AXI_DATA_WIDTH-1:0] data;
	} w_t;

	typedef struct packed {
		logic [`AXI_ADDR_WIDTH-1:0] addr;
		logic [2:0]                 size;
	} ar_t;

	typedef struct packed {
		logic [`AXI_DATA_WIDTH-1:0] data;
		resp_e                      resp;
	} r_t;

	typedef struct packed {
		resp_e resp;
	} b_t;

endpackage

// ==== design/apb_pkg.sv ====
`include "bridge_settings.svh"

package apb_pkg;

	// one APB word transfer
	typedef struct packed {
		logic [`APB_SEL_WIDTH-1:0]  sel;
		logic [`APB_ADDR_WIDTH-1:0] addr;
		logic                       write;
		logic [`APB_DATA_WIDTH-1:0] wdata;
		logic                       lane;
		logic                       last;
	} cmd_t;

	typedef struct packed {
		logic [`APB_DATA_WIDTH-1:0] rdata;
		logic                       err;
		logic                       lane;
		logic                       last;
		logic                       write;
	} result_t;

endpackage

// ==== design/chan_buffer.sv ====
`include "bridge_settings.svh"

module chan_buffer #(
	parameter type payload_t = logic
) (
	input  logic     ACLK,
	input  logic     ARESETn,
	input  logic     in_valid_i,
	input  payload_t in_data_i,
	output logic     in_ready_o,
	output logic     out_valid_o,
	output payload_t out_data_o,
	input  logic     out_ready_i
);
	localparam int DEPTH = `BUFFER_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign in_ready_o  = (count != CNT_W'(DEPTH));
	assign out_valid_o = (count != '0);
	assign out_data_o  = mem[rd_ptr];
	assign push = in_valid_i & in_ready_o;
	assign pop  = out_valid_o & out_ready_i;

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			// simultaneous push and pop keeps the count
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge ACLK) begin
		if (push)
			mem[wr_ptr] <= in_data_i;
	end

endmodule

// ==== design/req_sequencer.sv ====
`include "bridge_settings.svh"

module req_sequencer (
	input  logic          ACLK,
	input  logic          ARESETn,
	input  logic          aw_valid_i,
	input  axi_pkg::aw_t  aw_i,
	output logic          aw_ready_o,
	input  logic          w_valid_i,
	input  axi_pkg::w_t   w_i,
	output logic          w_ready_o,
	input  logic          ar_valid_i,
	input  axi_pkg::ar_t  ar_i,
	output logic          ar_ready_o,
	output logic          cmd_valid_o,
	output apb_pkg::cmd_t cmd_o,
	input  logic          cmd_ready_i
);
	logic busy;
	logic is_read;
	logic second;
	logic [`AXI_ADDR_WIDTH-1:0] addr;
	logic [2:0] size;
	logic wide;
	logic lane;
	logic cmd_done;

	assign addr = is_read ? ar_i.addr : aw_i.addr;
	assign size = is_read ? ar_i.size : aw_i.size;
	// 8-byte access goes out as two words
	assign wide = (size == 3'd3);
	assign lane = wide ? second : addr[2];

	assign cmd_valid_o = busy;

	always_comb begin
		cmd_o.sel   = addr[`APB_ADDR_WIDTH +: `APB_SEL_WIDTH];
		cmd_o.addr  = {addr[`APB_ADDR_WIDTH-1:3], lane, 2'b00};
		cmd_o.write = ~is_read;
		cmd_o.wdata = w_i.data[lane*`APB_DATA_WIDTH +: `APB_DATA_WIDTH];
		cmd_o.lane  = lane;
		cmd_o.last  = ~wide | second;
	end

	// heads are released with the final word
	assign cmd_done   = busy & cmd_ready_i & cmd_o.last;
	assign ar_ready_o = cmd_done & is_read;
	assign aw_ready_o = cmd_done & ~is_read;
	assign w_ready_o  = cmd_done & ~is_read;

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			busy    <= 1'b0;
			is_read <= 1'b0;
			second  <= 1'b0;
		end else if (!busy) begin
			second <= 1'b0;
			// reads win over writes
			if (ar_valid_i) begin
				busy    <= 1'b1;
				is_read <= 1'b1;
			end else if (aw_valid_i && w_valid_i) begin
				busy    <= 1'b1;
				is_read <= 1'b0;
			end
		end else if (cmd_valid_o && cmd_ready_i) begin
			if (cmd_o.last)
				busy <= 1'b0;
			else
				second <= 1'b1;
		end
	end

endmodule

// ==== design/apb_master.sv ====
`include "bridge_settings.svh"

module apb_master (
	input  logic                                       ACLK,
	input  logic                                       ARESETn,
	input  logic                                       cmd_valid_i,
	input  apb_pkg::cmd_t                              cmd_i,
	output logic                                       cmd_ready_o,
	output logic                                       res_valid_o,
	output apb_pkg::result_t                           res_o,
	input  logic                                       res_ready_i,
	output logic [`APB_NUM_SLAVES-1:0]                 PSEL_o,
	output logic                                       PENABLE_o,
	output logic                                       PWRITE_o,
	output logic [`APB_ADDR_WIDTH-1:0]                 PADDR_o,
	output logic [`APB_DATA_WIDTH-1:0]                 PWDATA_o,
	input  logic [`APB_NUM_SLAVES*`APB_DATA_WIDTH-1:0] PRDATA_i,
	input  logic [`APB_NUM_SLAVES-1:0]                 PREADY_i,
	input  logic [`APB_NUM_SLAVES-1:0]                 PSLVERR_i
);
	typedef enum logic [1:0] {
		st_idle,
		st_setup,
		st_access,
		st_done
	} state_e;

	state_e state;
	apb_pkg::cmd_t cmd_q;
	logic [`APB_DATA_WIDTH-1:0] rdata_q;
	logic err_q;
	logic sel_ready;
	logic sel_err;
	logic [`APB_DATA_WIDTH-1:0] sel_rdata;
	logic [`APB_NUM_SLAVES-1:0] psel;

	// response of the addressed slave only
	assign sel_ready = PREADY_i[cmd_q.sel];
	assign sel_err   = PSLVERR_i[cmd_q.sel];
	assign sel_rdata = PRDATA_i[cmd_q.sel*`APB_DATA_WIDTH +: `APB_DATA_WIDTH];

	assign cmd_ready_o = (state == st_idle);
	assign res_valid_o = (state == st_done);

	always_comb begin
		res_o.rdata = rdata_q;
		res_o.err   = err_q;
		res_o.lane  = cmd_q.lane;
		res_o.last  = cmd_q.last;
		res_o.write = cmd_q.write;
	end

	always_comb begin
		psel = '0;
		if (state == st_setup || state == st_access)
			psel[cmd_q.sel] = 1'b1;
	end

	assign PSEL_o    = psel;
	assign PENABLE_o = (state == st_access);
	assign PWRITE_o  = cmd_q.write;
	assign PADDR_o   = cmd_q.addr;
	assign PWDATA_o  = cmd_q.wdata;

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:   if (cmd_valid_i) state <= st_setup;
				st_setup:  state <= st_access;
				st_access: if (sel_ready) state <= st_done;
				// hold here so back-pressure never splits a transfer
				st_done:   if (res_ready_i) state <= st_idle;
				default:   state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge ACLK) begin
		if (cmd_valid_i && cmd_ready_o)
			cmd_q <= cmd_i;
		if (state == st_access && sel_ready) begin
			rdata_q <= sel_rdata;
			err_q   <= sel_err;
		end
	end

endmodule

// ==== design/resp_assembler.sv ====
`include "bridge_settings.svh"

module resp_assembler (
	input  logic                       ACLK,
	input  logic                       ARESETn,
	input  logic                       res_valid_i,
	input  apb_pkg::result_t           res_i,
	output logic                       res_ready_o,
	output logic [1:0]                 BRESP_o,
	output logic                       BVALID_o,
	input  logic                       BREADY_i,
	output logic [`AXI_DATA_WIDTH-1:0] RDATA_o,
	output logic [1:0]                 RRESP_o,
	output logic                       RLAST_o,
	output logic                       RVALID_o,
	input  logic                       RREADY_i
);
	logic fresh;
	logic [`AXI_DATA_WIDTH-1:0] data_q;
	logic err_q;
	logic [`AXI_DATA_WIDTH-1:0] data_acc;
	logic err_acc;
	logic res_fire;
	logic b_push;
	logic b_room;
	logic r_push;
	logic r_room;
	axi_pkg::resp_e resp;
	axi_pkg::b_t b_in;
	axi_pkg::b_t b_out;
	axi_pkg::r_t r_in;
	axi_pkg::r_t r_out;

	// lanes without a word stay zero
	always_comb begin
		data_acc = fresh ? '0 : data_q;
		data_acc[res_i.lane*`APB_DATA_WIDTH +: `APB_DATA_WIDTH] = res_i.rdata;
		err_acc = (~fresh & err_q) | res_i.err;
		if (err_acc)
			resp = axi_pkg::SLVERR;
		else
			resp = axi_pkg::OKAY;
	end

	assign res_ready_o = res_i.write ? b_room : r_room;
	assign res_fire    = res_valid_i & res_ready_o;
	assign b_push      = res_fire & res_i.last & res_i.write;
	assign r_push      = res_fire & res_i.last & ~res_i.write;

	assign b_in = '{resp: resp};
	assign r_in = '{data: data_acc, resp: resp};

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn)
			fresh <= 1'b1;
		else if (res_fire)
			fresh <= res_i.last;
	end

	always_ff @(posedge ACLK) begin
		if (res_fire) begin
			data_q <= data_acc;
			err_q  <= err_acc;
		end
	end

	chan_buffer #(.payload_t(axi_pkg::b_t)) b_buf (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.in_valid_i  (b_push),
		.in_data_i   (b_in),
		.in_ready_o  (b_room),
		.out_valid_o (BVALID_o),
		.out_data_o  (b_out),
		.out_ready_i (BREADY_i)
	);

	chan_buffer #(.payload_t(axi_pkg::r_t)) r_buf (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.in_valid_i  (r_push),
		.in_data_i   (r_in),
		.in_ready_o  (r_room),
		.out_valid_o (RVALID_o),
		.out_data_o  (r_out),
		.out_ready_i (RREADY_i)
	);

	assign BRESP_o = b_out.resp;
	assign RDATA_o = r_out.data;
	assign RRESP_o = r_out.resp;
	// single-beat transactions only
	assign RLAST_o = 1'b1;

endmodule

// ==== design/axi_apb_bridge.sv ====
`include "bridge_settings.svh"

module axi_apb_bridge (
	input  logic                                       ACLK,
	input  logic                                       ARESETn,
	input  logic [`AXI_ADDR_WIDTH-1:0]                 AWADDR_i,
	input  logic [2:0]                                 AWSIZE_i,
	input  logic                                       AWVALID_i,
	output logic                                       AWREADY_o,
	input  logic [`AXI_DATA_WIDTH-1:0]                 WDATA_i,
	input  logic                                       WVALID_i,
	output logic                                       WREADY_o,
	output logic [1:0]                                 BRESP_o,
	output logic                                       BVALID_o,
	input  logic                                       BREADY_i,
	input  logic [`AXI_ADDR_WIDTH-1:0]                 ARADDR_i,
	input  logic [2:0]                                 ARSIZE_i,
	input  logic                                       ARVALID_i,
	output logic                                       ARREADY_o,
	output logic [`AXI_DATA_WIDTH-1:0]                 RDATA_o,
	output logic [1:0]                                 RRESP_o,
	output logic                                       RLAST_o,
	output logic                                       RVALID_o,
	input  logic                                       RREADY_i,
	output logic [`APB_NUM_SLAVES-1:0]                 PSEL_o,
	output logic                                       PENABLE_o,
	output logic                                       PWRITE_o,
	output logic [`APB_ADDR_WIDTH-1:0]                 PADDR_o,
	output logic [`APB_DATA_WIDTH-1:0]                 PWDATA_o,
	input  logic [`APB_NUM_SLAVES*`APB_DATA_WIDTH-1:0] PRDATA_i,
	input  logic [`APB_NUM_SLAVES-1:0]                 PREADY_i,
	input  logic [`APB_NUM_SLAVES-1:0]                 PSLVERR_i
);
	axi_pkg::aw_t aw_in;
	axi_pkg::aw_t aw_head;
	axi_pkg::w_t w_in;
	axi_pkg::w_t w_head;
	axi_pkg::ar_t ar_in;
	axi_pkg::ar_t ar_head;
	logic aw_valid;
	logic aw_ready;
	logic w_valid;
	logic w_ready;
	logic ar_valid;
	logic ar_ready;
	apb_pkg::cmd_t cmd;
	logic cmd_valid;
	logic cmd_ready;
	apb_pkg::result_t res;
	logic res_valid;
	logic res_ready;

	assign aw_in = '{addr: AWADDR_i, size: AWSIZE_i};
	assign w_in  = '{data: WDATA_i};
	assign ar_in = '{addr: ARADDR_i, size: ARSIZE_i};

	chan_buffer #(.payload_t(axi_pkg::aw_t)) u_aw_buf (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.in_valid_i  (AWVALID_i),
		.in_data_i   (aw_in),
		.in_ready_o  (AWREADY_o),
		.out_valid_o (aw_valid),
		.out_data_o  (aw_head),
		.out_ready_i (aw_ready)
	);

	chan_buffer #(.payload_t(axi_pkg::w_t)) u_w_buf (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.in_valid_i  (WVALID_i),
		.in_data_i   (w_in),
		.in_ready_o  (WREADY_o),
		.out_valid_o (w_valid),
		.out_data_o  (w_head),
		.out_ready_i (w_ready)
	);

	chan_buffer #(.payload_t(axi_pkg::ar_t)) u_ar_buf (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.in_valid_i  (ARVALID_i),
		.in_data_i   (ar_in),
		.in_ready_o  (ARREADY_o),
		.out_valid_o (ar_valid),
		.out_data_o  (ar_head),
		.out_ready_i (ar_ready)
	);

	req_sequencer u_req_sequencer (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.aw_valid_i  (aw_valid),
		.aw_i        (aw_head),
		.aw_ready_o  (aw_ready),
		.w_valid_i   (w_valid),
		.w_i         (w_head),
		.w_ready_o   (w_ready),
		.ar_valid_i  (ar_valid),
		.ar_i        (ar_head),
		.ar_ready_o  (ar_ready),
		.cmd_valid_o (cmd_valid),
		.cmd_o       (cmd),
		.cmd_ready_i (cmd_ready)
	);

	apb_master u_apb_master (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.cmd_valid_i (cmd_valid),
		.cmd_i       (cmd),
		.cmd_ready_o (cmd_ready),
		.res_valid_o (res_valid),
		.res_o       (res),
		.res_ready_i (res_ready),
		.PSEL_o      (PSEL_o),
		.PENABLE_o   (PENABLE_o),
		.PWRITE_o    (PWRITE_o),
		.PADDR_o     (PADDR_o),
		.PWDATA_o    (PWDATA_o),
		.PRDATA_i    (PRDATA_i),
		.PREADY_i    (PREADY_i),
		.PSLVERR_i   (PSLVERR_i)
	);

	resp_assembler u_resp_assembler (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.res_valid_i (res_valid),
		.res_i       (res),
		.res_ready_o (res_ready),
		.BRESP_o     (BRESP_o),
		.BVALID_o    (BVALID_o),
		.BREADY_i    (BREADY_i),
		.RDATA_o     (RDATA_o),
		.RRESP_o     (RRESP_o),
		.RLAST_o     (RLAST_o),
		.RVALID_o    (RVALID_o),
		.RREADY_i    (RREADY_i)
	);

endmodule

// ==== testbench/apb_slave_model.sv ====
`include "bridge_settings.svh"

module apb_slave_model (
	input  logic                                       ACLK,
	input  logic                                       ARESETn,
	input  logic [`APB_NUM_SLAVES-1:0]                 psel_i,
	input  logic                                       penable_i,
	input  logic                                       pwrite_i,
	input  logic [`APB_ADDR_WIDTH-1:0]                 paddr_i,
	input  logic [`APB_DATA_WIDTH-1:0]                 pwdata_i,
	input  logic [1:0]                                 wait_i,
	output logic [`APB_NUM_SLAVES*`APB_DATA_WIDTH-1:0] prdata_o,
	output logic [`APB_NUM_SLAVES-1:0]                 pready_o,
	output logic [`APB_NUM_SLAVES-1:0]                 pslverr_o
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WORDS = 2 ** (`APB_ADDR_WIDTH - 2);
	localparam int ERR_SLAVE = 7;

	logic [`APB_DATA_WIDTH-1:0] mem [`APB_NUM_SLAVES][WORDS];
	logic [1:0] wait_cnt;

	initial begin
		for (int s = 0; s < `APB_NUM_SLAVES; s++)
			for (int a = 0; a < WORDS; a++)
				mem[s][a] = '0;
	end

	// one transfer at a time, so one counter serves all slaves
	always @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn)
			wait_cnt <= '0;
		else if (|psel_i && !penable_i)
			wait_cnt <= wait_i;
		else if (|psel_i && wait_cnt != '0)
			wait_cnt <= wait_cnt - 1'b1;
	end

	for (genvar s = 0; s < `APB_NUM_SLAVES; s++) begin : g_slave
		assign prdata_o[s*`APB_DATA_WIDTH +: `APB_DATA_WIDTH] = mem[s][paddr_i[`APB_ADDR_WIDTH-1:2]];
		assign pready_o[s]  = psel_i[s] & penable_i & (wait_cnt == '0);
		assign pslverr_o[s] = (s == ERR_SLAVE) & pready_o[s];
	end

	// last slave drops writes and flags every transfer
	always @(posedge ACLK) begin
		for (int s = 0; s < ERR_SLAVE; s++)
			if (psel_i[s] && penable_i && pready_o[s] && pwrite_i)
				mem[s][paddr_i[`APB_ADDR_WIDTH-1:2]] <= pwdata_i;
	end

endmodule

// ==== testbench/tb_axi_apb_bridge.sv ====
`include "bridge_settings.svh"

module tb_axi_apb_bridge;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_ROWS = 32;
	localparam int TIMEOUT = 1000;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic        write;
		logic        sync;
		logic [31:0] addr;
		logic [2:0]  size;
		logic [63:0] wdata;
		logic [63:0] rdata;
		logic [1:0]  resp;
	} row_t;

	logic ACLK = 1'b0;
	logic ARESETn;
	logic [`AXI_ADDR_WIDTH-1:0] aw_addr;
	logic [2:0] aw_size;
	logic aw_valid;
	logic aw_ready;
	logic [`AXI_DATA_WIDTH-1:0] w_data;
	logic w_valid;
	logic w_ready;
	logic [1:0] b_resp;
	logic b_valid;
	logic b_ready;
	logic [`AXI_ADDR_WIDTH-1:0] ar_addr;
	logic [2:0] ar_size;
	logic ar_valid;
	logic ar_ready;
	logic [`AXI_DATA_WIDTH-1:0] r_data;
	logic [1:0] r_resp;
	logic r_last;
	logic r_valid;
	logic r_ready;
	logic [`APB_NUM_SLAVES-1:0] psel;
	logic penable;
	logic pwrite;
	logic [`APB_ADDR_WIDTH-1:0] paddr;
	logic [`APB_DATA_WIDTH-1:0] pwdata;
	logic [`APB_NUM_SLAVES*`APB_DATA_WIDTH-1:0] prdata;
	logic [`APB_NUM_SLAVES-1:0] pready;
	logic [`APB_NUM_SLAVES-1:0] pslverr;
	logic [31:0] rng_state = 32'd87570;

	row_t rows [MAX_ROWS];
	int num_rows = 0;
	int rows_issued = 0;
	int b_done = 0;
	int r_done = 0;

	always #20 ACLK = ~ACLK;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// fresh value on the falling edge, read after the rising edge
	always @(negedge ACLK)
		rng_state <= lcg_next(rng_state);

	axi_apb_bridge u_axi_apb_bridge (
		.ACLK      (ACLK),
		.ARESETn   (ARESETn),
		.AWADDR_i  (aw_addr),
		.AWSIZE_i  (aw_size),
		.AWVALID_i (aw_valid),
		.AWREADY_o (aw_ready),
		.WDATA_i   (w_data),
		.WVALID_i  (w_valid),
		.WREADY_o  (w_ready),
		.BRESP_o   (b_resp),
		.BVALID_o  (b_valid),
		.BREADY_i  (b_ready),
		.ARADDR_i  (ar_addr),
		.ARSIZE_i  (ar_size),
		.ARVALID_i (ar_valid),
		.ARREADY_o (ar_ready),
		.RDATA_o   (r_data),
		.RRESP_o   (r_resp),
		.RLAST_o   (r_last),
		.RVALID_o  (r_valid),
		.RREADY_i  (r_ready),
		.PSEL_o    (psel),
		.PENABLE_o (penable),
		.PWRITE_o  (pwrite),
		.PADDR_o   (paddr),
		.PWDATA_o  (pwdata),
		.PRDATA_i  (prdata),
		.PREADY_i  (pready),
		.PSLVERR_i (pslverr)
	);

	apb_slave_model u_apb_slave_model (
		.ACLK      (ACLK),
		.ARESETn   (ARESETn),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.wait_i    (rng_state[17:16]),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr)
	);

	task automatic step();
		@(posedge ACLK);
		#2;
	endtask

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check(input logic [63:0] actual, input logic [63:0] expected, input string what);
		if (actual !== expected)
			fail_run($sformatf("error at %0d ns: %s: got %h, expected %h",
				$time, what, actual, expected));
	endtask

	task automatic add_row(input logic write, input logic sync, input logic [31:0] addr,
		input logic [2:0] size, input logic [63:0] wdata, input logic [63:0] rdata,
		input logic [1:0] resp);
		rows[num_rows] = {write, sync, addr, size, wdata, rdata, resp};
		num_rows++;
	endtask

	task automatic build_table();
		// full word round trip in slave 0
		add_row(1, 1, 32'h0000_0010, 3'd3, 64'h1122_3344_5566_7788, 64'h0, RESP_OKAY);
		add_row(0, 1, 32'h0000_0010, 3'd3, 64'h0, 64'h1122_3344_5566_7788, RESP_OKAY);
		// narrow accesses land in the lane of address bit 2
		add_row(1, 1, 32'h0000_0014, 3'd2, 64'hAAAA_BBBB_CCCC_DDDD, 64'h0, RESP_OKAY);
		add_row(0, 1, 32'h0000_0010, 3'd3, 64'h0, 64'hAAAA_BBBB_5566_7788, RESP_OKAY);
		add_row(0, 1, 32'h0000_0010, 3'd2, 64'h0, 64'h0000_0000_5566_7788, RESP_OKAY);
		add_row(0, 1, 32'h0000_0014, 3'd2, 64'h0, 64'hAAAA_BBBB_0000_0000, RESP_OKAY);
		// same offset in slaves 0, 3 and 5
		add_row(1, 1, 32'h0000_0040, 3'd3, 64'h0101_0101_1010_1010, 64'h0, RESP_OKAY);
		add_row(1, 1, 32'h0000_3040, 3'd3, 64'h0303_0303_3030_3030, 64'h0, RESP_OKAY);
		add_row(1, 1, 32'h0000_5040, 3'd3, 64'h0505_0505_5050_5050, 64'h0, RESP_OKAY);
		add_row(0, 1, 32'h0000_0040, 3'd3, 64'h0, 64'h0101_0101_1010_1010, RESP_OKAY);
		add_row(0, 1, 32'h0000_3040, 3'd3, 64'h0, 64'h0303_0303_3030_3030, RESP_OKAY);
		add_row(0, 1, 32'h0000_5040, 3'd3, 64'h0, 64'h0505_0505_5050_5050, RESP_OKAY);
		// slave 7 errors on everything
		add_row(1, 1, 32'h0000_7008, 3'd3, 64'hDEAD_BEEF_0BAD_F00D, 64'h0, RESP_SLVERR);
		add_row(0, 1, 32'h0000_7008, 3'd3, 64'h0, 64'h0, RESP_SLVERR);
		add_row(0, 1, 32'h0000_7004, 3'd2, 64'h0, 64'h0, RESP_SLVERR);
		// back-to-back, no read touches a word written in this group
		add_row(1, 0, 32'h0000_2000, 3'd3, 64'h2222_0000_2222_0001, 64'h0, RESP_OKAY);
		add_row(0, 0, 32'h0000_0040, 3'd3, 64'h0, 64'h0101_0101_1010_1010, RESP_OKAY);
		add_row(1, 0, 32'h0000_2008, 3'd3, 64'h2222_0000_2222_0002, 64'h0, RESP_OKAY);
		add_row(1, 0, 32'h0000_4004, 3'd2, 64'h4444_4444_0000_0000, 64'h0, RESP_OKAY);
		add_row(0, 0, 32'h0000_3040, 3'd3, 64'h0, 64'h0303_0303_3030_3030, RESP_OKAY);
		add_row(0, 0, 32'h0000_7010, 3'd3, 64'h0, 64'h0, RESP_SLVERR);
		add_row(1, 0, 32'h0000_6010, 3'd3, 64'h6666_7777_8888_9999, 64'h0, RESP_OKAY);
		add_row(0, 0, 32'h0000_5044, 3'd2, 64'h0, 64'h0505_0505_0000_0000, RESP_OKAY);
		add_row(1, 0, 32'h0000_7000, 3'd2, 64'h1234_5678_9ABC_DEF0, 64'h0, RESP_SLVERR);
		// read back what the pipelined writes stored
		add_row(0, 1, 32'h0000_2000, 3'd3, 64'h0, 64'h2222_0000_2222_0001, RESP_OKAY);
		add_row(0, 1, 32'h0000_2008, 3'd3, 64'h0, 64'h2222_0000_2222_0002, RESP_OKAY);
		add_row(0, 1, 32'h0000_4000, 3'd3, 64'h0, 64'h4444_4444_0000_0000, RESP_OKAY);
		add_row(0, 1, 32'h0000_6010, 3'd3, 64'h0, 64'h6666_7777_8888_9999, RESP_OKAY);
	endtask

	task automatic check_quiet(input string when);
		check(b_valid, 0, {"BVALID ", when});
		check(r_valid, 0, {"RVALID ", when});
		check(penable, 0, {"PENABLE ", when});
		check(psel, 0, {"PSEL ", when});
	endtask

	task automatic reset_and_check();
		ARESETn = 1'b0;
		repeat (5) begin
			step();
			check_quiet("during reset");
		end
		ARESETn = 1'b1;
		step();
		check_quiet("after reset");
		check(aw_ready, 1, "AWREADY after reset");
		check(w_ready, 1, "WREADY after reset");
		check(ar_ready, 1, "ARREADY after reset");
	endtask

	task automatic issue_rows();
		int cycles;
		logic aw_fire;
		logic w_fire;
		logic ar_fire;
		for (int i = 0; i < num_rows; i++) begin
			cycles = 0;
			while (rows[i].sync && b_done + r_done < rows_issued) begin
				step();
				cycles++;
				if (cycles > TIMEOUT)
					fail_run($sformatf("timeout: responses before row %0d never arrived", i));
			end
			cycles = 0;
			if (rows[i].write) begin
				aw_addr = rows[i].addr;
				aw_size = rows[i].size;
				w_data = rows[i].wdata;
				aw_valid = 1'b1;
				w_valid = 1'b1;
				while (aw_valid || w_valid) begin
					aw_fire = aw_valid & aw_ready;
					w_fire = w_valid & w_ready;
					step();
					if (aw_fire)
						aw_valid = 1'b0;
					if (w_fire)
						w_valid = 1'b0;
					cycles++;
					if (cycles > TIMEOUT)
						fail_run($sformatf("timeout: AW/W handshake of row %0d never completed", i));
				end
			end else begin
				ar_addr = rows[i].addr;
				ar_size = rows[i].size;
				ar_valid = 1'b1;
				while (ar_valid) begin
					ar_fire = ar_ready;
					step();
					if (ar_fire)
						ar_valid = 1'b0;
					cycles++;
					if (cycles > TIMEOUT)
						fail_run($sformatf("timeout: AR handshake of row %0d never completed", i));
				end
			end
			rows_issued++;
		end
	endtask

	task automatic collect_b();
		int cycles;
		int hold;
		logic [1:0] first_resp;
		for (int i = 0; i < num_rows; i++) begin
			if (rows[i].write) begin
				cycles = 0;
				while (rows_issued <= i || !b_valid) begin
					step();
					cycles++;
					if (cycles > TIMEOUT)
						fail_run($sformatf("timeout: B handshake of row %0d never completed", i));
				end
				hold = rng_state[21:20];
				first_resp = b_resp;
				// stalled response has to hold still
				repeat (hold) begin
					step();
					check(b_valid, 1, $sformatf("row %0d BVALID while stalled", i));
					check(b_resp, first_resp, $sformatf("row %0d BRESP while stalled", i));
				end
				check(b_resp, rows[i].resp, $sformatf("row %0d BRESP", i));
				b_ready = 1'b1;
				step();
				b_ready = 1'b0;
				b_done++;
			end
		end
	endtask

	task automatic collect_r();
		int cycles;
		int hold;
		logic [63:0] first_data;
		logic [1:0] first_resp;
		for (int i = 0; i < num_rows; i++) begin
			if (!rows[i].write) begin
				cycles = 0;
				while (rows_issued <= i || !r_valid) begin
					step();
					cycles++;
					if (cycles > TIMEOUT)
						fail_run($sformatf("timeout: R handshake of row %0d never completed", i));
				end
				hold = rng_state[25:24];
				first_data = r_data;
				first_resp = r_resp;
				repeat (hold) begin
					step();
					check(r_valid, 1, $sformatf("row %0d RVALID while stalled", i));
					check(r_data, first_data, $sformatf("row %0d RDATA while stalled", i));
					check(r_resp, first_resp, $sformatf("row %0d RRESP while stalled", i));
				end
				check(r_data, rows[i].rdata, $sformatf("row %0d RDATA", i));
				check(r_resp, rows[i].resp, $sformatf("row %0d RRESP", i));
				check(r_last, 1, $sformatf("row %0d RLAST", i));
				r_ready = 1'b1;
				step();
				r_ready = 1'b0;
				r_done++;
			end
		end
	endtask

	initial begin
		ARESETn = 1'b0;
		aw_addr = '0;
		aw_size = '0;
		aw_valid = 1'b0;
		w_data = '0;
		w_valid = 1'b0;
		b_ready = 1'b0;
		ar_addr = '0;
		ar_size = '0;
		ar_valid = 1'b0;
		r_ready = 1'b0;
		build_table();
		reset_and_check();
		fork
			issue_rows();
			collect_b();
			collect_r();
		join
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+design
design/axi_pkg.sv
design/apb_pkg.sv
design/chan_buffer.sv
design/req_sequencer.sv
design/apb_master.sv
design/resp_assembler.sv
design/axi_apb_bridge.sv
testbench/apb_slave_model.sv
testbench/tb_axi_apb_bridge.sv

// ==== Bender.yml ====
package:
  name: axi_apb_bridge

export_include_dirs:
  - design

sources:
  - files:
      - design/axi_pkg.sv
      - design/apb_pkg.sv
      - design/chan_buffer.sv
      - design/req_sequencer.sv
      - design/apb_master.sv
      - design/resp_assembler.sv
      - design/axi_apb_bridge.sv
  - target: test
    files:
      - testbench/apb_slave_model.sv
      - testbench/tb_axi_apb_bridge.sv
